//--- rtl/mm_bus_pkg.sv
/*
 * word-level types shared by the data port and the interrupt interface
 * the instruction port width is a module parameter and has no type here
 */
package mm_bus_pkg;

    // data port address or data word
    typedef logic [31:0] word_t;

    // one enable per byte of a word, bit 0 is the lowest byte
    typedef logic [3:0] be_t;

    // interrupt id from the core's acknowledge
    typedef logic [4:0] irq_id_t;

endpackage

//--- rtl/mm_map_pkg.sv
/*
 * memory map of the model and the magic values the test programs use
 * the addresses are exact, peripherals decode full 32-bit matches only
 */
package mm_map_pkg;

    // character output, low byte of the written word
    localparam logic [31:0] PRINT_ADDR      = 32'h1000_0000;

    // timer registers
    localparam logic [31:0] TIMER_MASK_ADDR = 32'h1500_0000;
    localparam logic [31:0] TIMER_CNT_ADDR  = 32'h1500_0004;

    // readable peripheral that always returns zero
    localparam logic [31:0] PER_READ_ADDR   = 32'h1500_1000;

    // test result and exit value
    localparam logic [31:0] STATUS_ADDR     = 32'h2000_0000;
    localparam logic [31:0] EXIT_ADDR       = 32'h2000_0004;

    // values written to STATUS_ADDR
    localparam logic [31:0] PASS_MAGIC      = 32'd123456789;
    localparam logic [31:0] FAIL_MAGIC      = 32'd1;

    // mask bit and acknowledge id of the timer interrupt
    localparam logic [4:0]  TIMER_IRQ_ID    = 5'd7;

    // where a data access goes
    // TGT_ERR covers unmapped addresses, TGT_NONE a cycle without request
    typedef enum logic [1:0] {
        TGT_RAM,
        TGT_PER,
        TGT_ERR,
        TGT_NONE
    } target_e;

endpackage

//--- rtl/mm_dp_ram.sv
/*
 * byte RAM of 2**RAM_ADDR_WIDTH bytes, no reset and no initial contents
 * the data port ignores the low two address bits and works on aligned words
 * an instruction fetch block must lie entirely inside the RAM
 */
`timescale 1ns/1ps

module mm_dp_ram #(
    parameter int RAM_ADDR_WIDTH    = 16,
    parameter int INSTR_RDATA_WIDTH = 128
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,

    input  logic                         instr_en_i,
    input  logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,

    input  logic                         data_en_i,
    input  logic                         data_we_i,
    input  logic [RAM_ADDR_WIDTH-1:0]    data_addr_i,
    input  mm_bus_pkg::be_t              data_be_i,
    input  mm_bus_pkg::word_t            data_wdata_i,
    output mm_bus_pkg::word_t            data_rdata_o
);

    localparam int RAM_BYTES   = 2 ** RAM_ADDR_WIDTH;
    localparam int INSTR_BYTES = INSTR_RDATA_WIDTH / 8;

    logic [7:0]                mem [RAM_BYTES];
    logic [RAM_ADDR_WIDTH-3:0] data_word_addr;

    assign data_word_addr = data_addr_i[RAM_ADDR_WIDTH-1:2];

    // instruction port, little-endian block from the fetch address upward
    always_ff @(posedge clk_i) begin
        if (instr_en_i) begin
            for (int i = 0; i < INSTR_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[instr_addr_i + RAM_ADDR_WIDTH'(i)];
            end
        end
    end

    // data port, only the enabled bytes are written
    always_ff @(posedge clk_i) begin
        if (data_en_i) begin
            if (data_we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_be_i[b]) begin
                        mem[{data_word_addr, 2'(b)}] <= data_wdata_i[8*b +: 8];
                    end
                end
            end else begin
                for (int b = 0; b < 4; b++) begin
                    data_rdata_o[8*b +: 8] <= mem[{data_word_addr, 2'(b)}];
                end
            end
        end
    end

    // a fetch block must not run past the top of the RAM
    instr_in_range_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        instr_en_i |-> (int'(instr_addr_i) + INSTR_BYTES <= RAM_BYTES)
    ) else $error("instruction fetch at %h leaves the RAM", instr_addr_i);

endmodule

//--- rtl/mm_addr_decode.sv
/*
 * combinational decode of the data port, RAM below 2**RAM_ADDR_WIDTH
 * peripherals match full addresses, RAM_ADDR_WIDTH must be below 32
 * strobes are high only in the cycle of the request that causes them
 */
`timescale 1ns/1ps

module mm_addr_decode #(
    parameter int RAM_ADDR_WIDTH = 16
) (
    // clock and reset feed the protocol checks only
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  logic                      data_req_i,
    input  logic                      data_we_i,
    input  mm_bus_pkg::word_t         data_addr_i,
    input  mm_bus_pkg::be_t           data_be_i,
    input  mm_bus_pkg::word_t         data_wdata_i,

    output logic                      ram_en_o,
    output logic                      ram_we_o,
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output mm_bus_pkg::be_t           ram_be_o,
    output mm_bus_pkg::word_t         ram_wdata_o,

    output logic                      timer_mask_we_o,
    output logic                      timer_cnt_we_o,
    output mm_bus_pkg::word_t         timer_wdata_o,

    output mm_map_pkg::target_e       target_o,

    output logic                      print_valid_o,
    output logic [7:0]                print_char_o,
    output logic                      tests_passed_o,
    output logic                      tests_failed_o,
    output logic                      exit_valid_o,
    output mm_bus_pkg::word_t         exit_value_o
);

    logic in_ram;

    assign in_ram = (data_addr_i[31:RAM_ADDR_WIDTH] == '0);

    // payload follows the bus, the strobes below qualify it
    assign ram_addr_o    = data_addr_i[RAM_ADDR_WIDTH-1:0];
    assign ram_be_o      = data_be_i;
    assign ram_wdata_o   = data_wdata_i;
    assign timer_wdata_o = data_wdata_i;
    assign print_char_o  = data_wdata_i[7:0];
    assign exit_value_o  = data_wdata_i;

    always_comb begin
        ram_en_o        = 1'b0;
        ram_we_o        = 1'b0;
        timer_mask_we_o = 1'b0;
        timer_cnt_we_o  = 1'b0;
        print_valid_o   = 1'b0;
        tests_passed_o  = 1'b0;
        tests_failed_o  = 1'b0;
        exit_valid_o    = 1'b0;
        target_o        = mm_map_pkg::TGT_NONE;

        if (data_req_i) begin
            if (in_ram) begin
                ram_en_o = 1'b1;
                ram_we_o = data_we_i;
                target_o = mm_map_pkg::TGT_RAM;
            end else if (data_we_i) begin
                target_o = mm_map_pkg::TGT_PER;
                case (data_addr_i)
                    mm_map_pkg::PRINT_ADDR:      print_valid_o   = 1'b1;
                    mm_map_pkg::TIMER_MASK_ADDR: timer_mask_we_o = 1'b1;
                    mm_map_pkg::TIMER_CNT_ADDR:  timer_cnt_we_o  = 1'b1;
                    mm_map_pkg::STATUS_ADDR: begin
                        // any other value is ignored
                        tests_passed_o = (data_wdata_i == mm_map_pkg::PASS_MAGIC);
                        tests_failed_o = (data_wdata_i == mm_map_pkg::FAIL_MAGIC);
                    end
                    mm_map_pkg::EXIT_ADDR:       exit_valid_o    = 1'b1;
                    default:                     target_o = mm_map_pkg::TGT_ERR;
                endcase
            end else if (data_addr_i == mm_map_pkg::PER_READ_ADDR) begin
                target_o = mm_map_pkg::TGT_PER;
            end else begin
                target_o = mm_map_pkg::TGT_ERR;
            end
        end
    end

    unmapped_write_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        data_req_i && data_we_i |-> target_o != mm_map_pkg::TGT_ERR
    ) else $error("write to unmapped address %h", data_addr_i);

    unmapped_read_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        data_req_i && !data_we_i |-> target_o != mm_map_pkg::TGT_ERR
    ) else $error("read from unmapped address %h", data_addr_i);

endmodule

//--- rtl/mm_timer.sv
/*
 * countdown timer, a count of N written at edge k raises the irq at k+N
 * the irq needs mask bit TIMER_IRQ_ID and stays high until acknowledged
 * a register write cycle holds the count and the irq
 */
`timescale 1ns/1ps

module mm_timer (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                mask_we_i,
    input  logic                cnt_we_i,
    input  mm_bus_pkg::word_t   wdata_i,
    input  logic                irq_ack_i,
    input  mm_bus_pkg::irq_id_t irq_id_i,
    output logic                irq_timer_o
);

    mm_bus_pkg::word_t mask_q;
    mm_bus_pkg::word_t cnt_q;
    logic              irq_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= 1'b0;
        end else if (mask_we_i) begin
            mask_q <= wdata_i;
        end else if (cnt_we_i) begin
            cnt_q <= wdata_i;
        end else begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 32'd1;
            end
            // fires on the step from 1 to 0
            if (cnt_q == 32'd1 && mask_q[mm_map_pkg::TIMER_IRQ_ID]) begin
                irq_q <= 1'b1;
            end
            // acknowledge wins over a set in the same cycle
            if (irq_ack_i && irq_id_i == mm_map_pkg::TIMER_IRQ_ID) begin
                irq_q <= 1'b0;
            end
        end
    end

    assign irq_timer_o = irq_q;

    // the decoder raises at most one register strobe per request
    one_timer_write_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(mask_we_i && cnt_we_i)
    ) else $error("timer mask and count written in the same cycle");

endmodule

//--- rtl/mm_data_resp.sv
/*
 * response stage that raises rvalid one cycle after every granted request
 * read data comes from the RAM only for RAM targets and is zero otherwise
 */
`timescale 1ns/1ps

module mm_data_resp (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                instr_req_i,
    input  logic                data_req_i,
    input  mm_map_pkg::target_e target_i,
    input  mm_bus_pkg::word_t   ram_rdata_i,
    output logic                instr_rvalid_o,
    output logic                data_rvalid_o,
    output mm_bus_pkg::word_t   data_rdata_o
);

    mm_map_pkg::target_e target_q;
    logic                instr_rvalid_q;
    logic                data_rvalid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            target_q       <= mm_map_pkg::TGT_NONE;
            instr_rvalid_q <= 1'b0;
            data_rvalid_q  <= 1'b0;
        end else begin
            target_q       <= target_i;
            instr_rvalid_q <= instr_req_i;
            data_rvalid_q  <= data_req_i;
        end
    end

    assign instr_rvalid_o = instr_rvalid_q;
    assign data_rvalid_o  = data_rvalid_q;

    // RAM read word lines up with the registered target
    always_comb begin
        if (target_q == mm_map_pkg::TGT_RAM) begin
            data_rdata_o = ram_rdata_i;
        end else begin
            data_rdata_o = '0;
        end
    end

endmodule

//--- rtl/mm_ram.sv
/*
 * memory model for a small RISC-V core, grants equal requests
 * no back-pressure, responses follow one cycle after each grant
 * INSTR_RDATA_WIDTH must be a multiple of 32
 */
`timescale 1ns/1ps

module mm_ram #(
    parameter int RAM_ADDR_WIDTH    = 16,
    parameter int INSTR_RDATA_WIDTH = 128
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,

    input  logic                         instr_req_i,
    input  logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic                         instr_gnt_o,
    output logic                         instr_rvalid_o,
    output logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,

    input  logic                         data_req_i,
    input  mm_bus_pkg::word_t            data_addr_i,
    input  logic                         data_we_i,
    input  mm_bus_pkg::be_t              data_be_i,
    input  mm_bus_pkg::word_t            data_wdata_i,
    output logic                         data_gnt_o,
    output logic                         data_rvalid_o,
    output mm_bus_pkg::word_t            data_rdata_o,

    input  mm_bus_pkg::irq_id_t          irq_id_i,
    input  logic                         irq_ack_i,
    output logic                         irq_timer_o,

    output logic                         print_valid_o,
    output logic [7:0]                   print_char_o,
    output logic                         tests_passed_o,
    output logic                         tests_failed_o,
    output logic                         exit_valid_o,
    output mm_bus_pkg::word_t            exit_value_o
);

    logic                      ram_en;
    logic                      ram_we;
    logic [RAM_ADDR_WIDTH-1:0] ram_addr;
    mm_bus_pkg::be_t           ram_be;
    mm_bus_pkg::word_t         ram_wdata;
    mm_bus_pkg::word_t         ram_rdata;
    logic                      timer_mask_we;
    logic                      timer_cnt_we;
    mm_bus_pkg::word_t         timer_wdata;
    mm_map_pkg::target_e       target;

    // grants never stall
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    mm_addr_decode #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) addr_decode_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .data_req_i      (data_req_i),
        .data_we_i       (data_we_i),
        .data_addr_i     (data_addr_i),
        .data_be_i       (data_be_i),
        .data_wdata_i    (data_wdata_i),
        .ram_en_o        (ram_en),
        .ram_we_o        (ram_we),
        .ram_addr_o      (ram_addr),
        .ram_be_o        (ram_be),
        .ram_wdata_o     (ram_wdata),
        .timer_mask_we_o (timer_mask_we),
        .timer_cnt_we_o  (timer_cnt_we),
        .timer_wdata_o   (timer_wdata),
        .target_o        (target),
        .print_valid_o   (print_valid_o),
        .print_char_o    (print_char_o),
        .tests_passed_o  (tests_passed_o),
        .tests_failed_o  (tests_failed_o),
        .exit_valid_o    (exit_valid_o),
        .exit_value_o    (exit_value_o)
    );

    mm_dp_ram #(
        .RAM_ADDR_WIDTH    (RAM_ADDR_WIDTH),
        .INSTR_RDATA_WIDTH (INSTR_RDATA_WIDTH)
    ) dp_ram_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .instr_en_i    (instr_req_i),
        .instr_addr_i  (instr_addr_i),
        .instr_rdata_o (instr_rdata_o),
        .data_en_i     (ram_en),
        .data_we_i     (ram_we),
        .data_addr_i   (ram_addr),
        .data_be_i     (ram_be),
        .data_wdata_i  (ram_wdata),
        .data_rdata_o  (ram_rdata)
    );

    mm_timer timer_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .mask_we_i   (timer_mask_we),
        .cnt_we_i    (timer_cnt_we),
        .wdata_i     (timer_wdata),
        .irq_ack_i   (irq_ack_i),
        .irq_id_i    (irq_id_i),
        .irq_timer_o (irq_timer_o)
    );

    mm_data_resp data_resp_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .data_req_i     (data_req_i),
        .target_i       (target),
        .ram_rdata_i    (ram_rdata),
        .instr_rvalid_o (instr_rvalid_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o)
    );

endmodule

//--- verif/mm_ram_tb.sv
/*
 * directed testbench for mm_ram with default parameters
 * a byte-array reference model follows every RAM write made through the data port
 */
`timescale 1ns/1ps

module mm_ram_tb;

    localparam int RAM_ADDR_WIDTH    = 16;
    localparam int INSTR_RDATA_WIDTH = 128;
    localparam int TIMEOUT           = 20;

    logic                         clk_i;
    logic                         rst_ni;
    logic                         instr_req_i;
    logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i;
    logic                         instr_gnt_o;
    logic                         instr_rvalid_o;
    logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o;
    logic                         data_req_i;
    mm_bus_pkg::word_t            data_addr_i;
    logic                         data_we_i;
    mm_bus_pkg::be_t              data_be_i;
    mm_bus_pkg::word_t            data_wdata_i;
    logic                         data_gnt_o;
    logic                         data_rvalid_o;
    mm_bus_pkg::word_t            data_rdata_o;
    mm_bus_pkg::irq_id_t          irq_id_i;
    logic                         irq_ack_i;
    logic                         irq_timer_o;
    logic                         print_valid_o;
    logic [7:0]                   print_char_o;
    logic                         tests_passed_o;
    logic                         tests_failed_o;
    logic                         exit_valid_o;
    mm_bus_pkg::word_t            exit_value_o;

    logic [7:0] ref_mem [2**RAM_ADDR_WIDTH];
    integer     seed = 32'hd340;
    int         errors = 0;
    int         tests_failed = 0;

    mm_ram mm_ram_i (.*);

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input mm_bus_pkg::word_t got,
                              input mm_bus_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // the caller may check the combinational outputs after this request cycle
    task automatic start_data(input logic we, input mm_bus_pkg::word_t addr,
                              input mm_bus_pkg::be_t be, input mm_bus_pkg::word_t wdata);
        @(posedge clk_i);
        data_req_i   <= 1'b1;
        data_we_i    <= we;
        data_addr_i  <= addr;
        data_be_i    <= be;
        data_wdata_i <= wdata;
        if (we && addr[31:RAM_ADDR_WIDTH] == '0) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    ref_mem[{addr[RAM_ADDR_WIDTH-1:2], 2'(b)}] = wdata[8*b +: 8];
                end
            end
        end
        @(negedge clk_i);
        check_bit("data_gnt_o", data_gnt_o, 1'b1);
    endtask

    // drops the request and waits for its response one cycle later
    task automatic finish_data(output mm_bus_pkg::word_t rdata);
        int cycles;
        @(posedge clk_i);
        data_req_i <= 1'b0;
        data_we_i  <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!data_rvalid_o && cycles < TIMEOUT);
        if (!data_rvalid_o) begin
            $display("data_rvalid_o never rose after the request");
            errors++;
        end else if (cycles != 1) begin
            $display("data_rvalid_o came %0d cycles after the request, not 1", cycles);
            errors++;
        end
        rdata = data_rdata_o;
    endtask

    task automatic data_access(input logic we, input mm_bus_pkg::word_t addr,
                               input mm_bus_pkg::be_t be, input mm_bus_pkg::word_t wdata,
                               output mm_bus_pkg::word_t rdata);
        start_data(we, addr, be, wdata);
        finish_data(rdata);
    endtask

    task automatic test_ram_rw();
        mm_bus_pkg::word_t         addrs [16];
        mm_bus_pkg::word_t         rdata;
        mm_bus_pkg::be_t           be;
        logic [RAM_ADDR_WIDTH-1:0] a;
        // a full word first so that every byte read back is known
        for (int i = 0; i < 16; i++) begin
            addrs[i] = $random(seed) & 32'h0000_fffc;
            data_access(1'b1, addrs[i], 4'hf, $random(seed), rdata);
            be = 4'($random(seed));
            data_access(1'b1, addrs[i], be, $random(seed), rdata);
        end
        for (int i = 0; i < 16; i++) begin
            a = addrs[i][RAM_ADDR_WIDTH-1:0];
            data_access(1'b0, addrs[i], 4'hf, 32'h0, rdata);
            check_word("data_rdata_o", rdata,
                       {ref_mem[a + 16'd3], ref_mem[a + 16'd2], ref_mem[a + 16'd1], ref_mem[a]});
        end
    endtask

    task automatic fetch_check(input logic [RAM_ADDR_WIDTH-1:0] addr);
        logic [INSTR_RDATA_WIDTH-1:0] exp;
        int                           cycles;
        for (int i = 0; i < INSTR_RDATA_WIDTH / 8; i++) begin
            exp[8*i +: 8] = ref_mem[addr + RAM_ADDR_WIDTH'(i)];
        end
        @(posedge clk_i);
        instr_req_i  <= 1'b1;
        instr_addr_i <= addr;
        @(negedge clk_i);
        check_bit("instr_gnt_o", instr_gnt_o, 1'b1);
        @(posedge clk_i);
        instr_req_i <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!instr_rvalid_o && cycles < TIMEOUT);
        if (!instr_rvalid_o) begin
            $display("instr_rvalid_o never rose after the fetch");
            errors++;
        end else if (cycles != 1) begin
            $display("instr_rvalid_o came %0d cycles after the fetch, not 1", cycles);
            errors++;
        end
        for (int w = 0; w < INSTR_RDATA_WIDTH / 32; w++) begin
            check_word("instr_rdata_o", instr_rdata_o[32*w +: 32], exp[32*w +: 32]);
        end
    endtask

    task automatic test_fetch();
        mm_bus_pkg::word_t base;
        mm_bus_pkg::word_t rdata;
        base = $random(seed) & 32'h0000_ffe0;
        for (int w = 0; w < 8; w++) begin
            data_access(1'b1, base + 32'(4 * w), 4'hf, $random(seed), rdata);
        end
        fetch_check(base[RAM_ADDR_WIDTH-1:0]);
        // unaligned block inside the filled range
        fetch_check(base[RAM_ADDR_WIDTH-1:0] + 16'd6);
    endtask

    task automatic result_write(input mm_bus_pkg::word_t addr, input mm_bus_pkg::word_t value,
                                input logic exp_passed, input logic exp_failed,
                                input logic exp_exit);
        mm_bus_pkg::word_t rdata;
        start_data(1'b1, addr, 4'hf, value);
        check_bit("tests_passed_o", tests_passed_o, exp_passed);
        check_bit("tests_failed_o", tests_failed_o, exp_failed);
        check_bit("exit_valid_o", exit_valid_o, exp_exit);
        if (exp_exit) begin
            check_word("exit_value_o", exit_value_o, value);
        end
        finish_data(rdata);
        check_bit("tests_passed_o", tests_passed_o, 1'b0);
        check_bit("tests_failed_o", tests_failed_o, 1'b0);
        check_bit("exit_valid_o", exit_valid_o, 1'b0);
    endtask

    task automatic test_print();
        mm_bus_pkg::word_t rnd;
        mm_bus_pkg::word_t rdata;
        for (int i = 0; i < 6; i++) begin
            rnd = $random(seed);
            start_data(1'b1, mm_map_pkg::PRINT_ADDR, 4'hf, rnd);
            check_bit("print_valid_o", print_valid_o, 1'b1);
            check_word("print_char_o", {24'h0, print_char_o}, {24'h0, rnd[7:0]});
            finish_data(rdata);
            check_bit("print_valid_o", print_valid_o, 1'b0);
        end
    endtask

    // starts at the negedge after the count write edge
    task automatic wait_irq(input int n);
        int cycles;
        cycles = 0;
        while (!irq_timer_o && cycles < n + TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!irq_timer_o) begin
            $display("irq_timer_o never rose after the count write");
            errors++;
        end else if (cycles != n) begin
            $display("irq_timer_o rose %0d cycles after the count write, not %0d", cycles, n);
            errors++;
        end
    endtask

    task automatic ack_irq(input mm_bus_pkg::irq_id_t id, input logic exp);
        @(posedge clk_i);
        irq_ack_i <= 1'b1;
        irq_id_i  <= id;
        @(posedge clk_i);
        irq_ack_i <= 1'b0;
        @(negedge clk_i);
        check_bit("irq_timer_o", irq_timer_o, exp);
    endtask

    task automatic test_timer();
        mm_bus_pkg::word_t rdata;
        int                n;
        n = 3 + ($random(seed) & 7);
        data_access(1'b1, mm_map_pkg::TIMER_MASK_ADDR, 4'hf,
                    $random(seed) | (32'h1 << mm_map_pkg::TIMER_IRQ_ID), rdata);
        data_access(1'b1, mm_map_pkg::TIMER_CNT_ADDR, 4'hf, 32'(n), rdata);
        wait_irq(n);
        ack_irq(5'd3, 1'b1);
        ack_irq(mm_map_pkg::TIMER_IRQ_ID, 1'b0);
        // with the mask bit clear the count runs out without an interrupt
        data_access(1'b1, mm_map_pkg::TIMER_MASK_ADDR, 4'hf,
                    $random(seed) & ~(32'h1 << mm_map_pkg::TIMER_IRQ_ID), rdata);
        data_access(1'b1, mm_map_pkg::TIMER_CNT_ADDR, 4'hf, 32'(n), rdata);
        repeat (n + 5) begin
            @(negedge clk_i);
            check_bit("irq_timer_o", irq_timer_o, 1'b0);
        end
    endtask

    task automatic report(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    initial begin
        int                mark;
        mm_bus_pkg::word_t rdata;
        rst_ni       <= 1'b0;
        instr_req_i  <= 1'b0;
        instr_addr_i <= '0;
        data_req_i   <= 1'b0;
        data_addr_i  <= '0;
        data_we_i    <= 1'b0;
        data_be_i    <= '0;
        data_wdata_i <= '0;
        irq_id_i     <= '0;
        irq_ack_i    <= 1'b0;
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;

        mark = errors;
        test_ram_rw();
        report("ram read and write", mark);
        mark = errors;
        test_fetch();
        report("instruction fetch", mark);
        mark = errors;
        result_write(mm_map_pkg::STATUS_ADDR, mm_map_pkg::PASS_MAGIC, 1'b1, 1'b0, 1'b0);
        result_write(mm_map_pkg::STATUS_ADDR, mm_map_pkg::FAIL_MAGIC, 1'b0, 1'b1, 1'b0);
        result_write(mm_map_pkg::STATUS_ADDR, 32'h0000_0042, 1'b0, 1'b0, 1'b0);
        result_write(mm_map_pkg::EXIT_ADDR, $random(seed), 1'b0, 1'b0, 1'b1);
        report("status and exit", mark);
        mark = errors;
        test_print();
        report("character output", mark);
        mark = errors;
        test_timer();
        report("timer", mark);
        mark = errors;
        data_access(1'b0, mm_map_pkg::PER_READ_ADDR, 4'hf, 32'h0, rdata);
        check_word("data_rdata_o", rdata, 32'h0);
        report("peripheral read", mark);

        $display("tests run 6, tests failed %0d, check errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/mm_bus_pkg.sv
rtl/mm_map_pkg.sv
rtl/mm_dp_ram.sv
rtl/mm_addr_decode.sv
rtl/mm_timer.sv
rtl/mm_data_resp.sv
rtl/mm_ram.sv
verif/mm_ram_tb.sv

//--- Makefile
# Verilator build and run of the mm_ram testbench

VERILATOR ?= verilator
TOP       ?= mm_ram_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Result: FAILED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# a crash or a nonzero exit counts as a failure too
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
